/* Bender.yml */
package:
  name: m68k_cache

sources:
  - files:
      - src/CachePkg.sv
      - src/CacheTagStore.sv
      - src/CacheDataStore.sv
      - src/CacheSequencer.sv
      - src/M68kCache.sv
  - target: test
    files:
      - testbench/M68kCacheTb.sv

/* M68kCache.f */
src/CachePkg.sv
src/CacheTagStore.sv
src/CacheDataStore.sv
src/CacheSequencer.sv
src/M68kCache.sv
testbench/M68kCacheTb.sv

/* src/CacheDataStore.sv */
/*
 * Line data memory: eight 16 bit words per line, addressed by line index
 * and word position. A burst fill writes one word per clock; the read is
 * combinational so the word is there in the same cycle as dtack.
 */
`timescale 1ns/1ps
`default_nettype none

module CacheDataStore #(
	parameter int IndexBits = 5
) (
	input wire logic Clock,
	input wire logic [IndexBits-1:0] index,
	input wire CachePkg::WordSelT wordSel,					// burst counter on fills, address bits 3:1 otherwise
	input wire logic wordWe,
	input wire CachePkg::DataWordT writeData,				// straight from the DRAM read bus
	output CachePkg::DataWordT readData
);

	import CachePkg::*;

	localparam int WordBits = $bits(WordSelT);
	localparam int Depth = (2 ** IndexBits) * (2 ** WordBits);

	DataWordT lineMem [0:Depth-1];							// line index in the upper address bits
	logic [IndexBits+WordBits-1:0] wordAddr;

	assign wordAddr = {index, wordSel};

	always_ff @(posedge Clock)
	begin
		if (wordWe)
		begin
			lineMem[wordAddr] <= writeData;					// one burst beat per clock
		end
	end

	assign readData = lineMem[wordAddr];					// asynchronous, no extra cycle on a hit

endmodule

`default_nettype wire

/* src/CachePkg.sv */
/*
 * Shared types for the 68000 read cache: bus word widths, the CPU and
 * DRAM controller bus structs and the sequencer state encoding.
 * Modules name these types with CachePkg:: in their headers.
 */
`default_nettype none

package CachePkg;

	typedef logic [31:0] AddressT;							// CPU byte address
	typedef logic [15:0] DataWordT;							// one 16 bit bus word
	typedef logic [2:0] WordSelT;							// word position, a line is always eight words

	// everything the 68000 drives towards the cache
	typedef struct packed {
		AddressT address;
		DataWordT writeData;
		logic udsL;											// upper byte strobe, active low
		logic ldsL;											// lower byte strobe, active low
		logic weL;											// write enable, low for a write
		logic asL;											// address strobe, held until dtack comes back
		logic dramSelect;									// address decoder says this is DRAM space
	} CpuBusT;

	typedef struct packed {
		AddressT address;									// line aligned on reads, exact on writes
		DataWordT writeData;
		logic udsL;
		logic ldsL;
		logic weL;
		logic asL;
		logic selectL;										// starts a DRAM cycle when low
	} DramReqT;

	typedef struct packed {
		DataWordT readData;
		logic dtackL;										// end of a DRAM write
		logic casL;											// low with ras high marks a read, not a refresh
		logic rasL;
	} DramStatusT;

	typedef enum logic [3:0] {
		StReset, StInvalidate, StIdle, StCheckHit, StHitWait, StFillStart,
		StCasDelay1, StCasDelay2, StBurstFill, StFillDone, StWrite
	} SeqStateT;

endpackage

`default_nettype wire

/* src/CacheSequencer.sv */
/*
 * Cache controller FSM. Clears every valid bit after reset, then serves
 * one CPU cycle at a time: hits from the data store, misses by a burst
 * fill from DRAM, writes passed through to DRAM with the line invalidated.
 */
`timescale 1ns/1ps
`default_nettype none

module CacheSequencer #(
	parameter int IndexBits = 5
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire CachePkg::CpuBusT cpu,
	input wire CachePkg::DramStatusT dramStatus,
	input wire logic hit,
	input wire logic lineValid,
	output CachePkg::DramReqT dramReq,
	output logic dtackToCpu,								// active low, to the 68000
	output logic [IndexBits-1:0] index,
	output logic tagWe,
	output logic validWe,
	output logic validIn,
	output CachePkg::WordSelT wordSel,
	output logic wordWe
);

	import CachePkg::*;

	localparam int CountBits = (IndexBits > 3) ? IndexBits : 3;
	localparam int LastLine = 2 ** IndexBits - 1;

	SeqStateT state, nextState;
	logic [CountBits-1:0] counter;							// lines during invalidate, words during a fill
	logic readStart, writeStart, cycleEnd;
	logic writePath;										// pass the CPU address and strobes to DRAM as is

	assign readStart = !cpu.asL && cpu.dramSelect && cpu.weL;
	assign writeStart = !cpu.asL && cpu.dramSelect && !cpu.weL;
	assign cycleEnd = cpu.asL || !cpu.dramSelect;			// CPU has let go of the bus cycle

	//////////////////////////////////////////////////
	// state and counter registers
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= StReset;
			counter <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == StInvalidate || state == StBurstFill)
			begin
				counter <= counter + 1'b1;					// only these two states count
			end
			else
			begin
				counter <= '0;								// so each starts from zero
			end
		end
	end

	//////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		index = cpu.address[IndexBits+3:4];					// line of the CPU address unless invalidating
		tagWe = 1'b0;
		validWe = 1'b0;
		validIn = 1'b0;
		wordWe = 1'b0;
		wordSel = cpu.address[3:1];							// the word the CPU asked for
		dtackToCpu = 1'b1;
		writePath = 1'b0;
		dramReq.address = {cpu.address[31:4], 4'b0000};	// reads always fetch from the start of the line
		dramReq.writeData = cpu.writeData;
		dramReq.udsL = 1'b0;								// both bytes on reads, the whole word gets cached
		dramReq.ldsL = 1'b0;
		dramReq.weL = 1'b1;
		dramReq.asL = cpu.asL;
		dramReq.selectL = 1'b1;

		case (state)
			StReset: nextState = StInvalidate;
			StInvalidate:
			begin
				index = counter[IndexBits-1:0];
				validWe = 1'b1;								// validIn stays low and clears the line
				if (counter == CountBits'(LastLine))
				begin
					nextState = StIdle;
				end
			end
			StIdle:
			begin
				if (readStart)
				begin
					nextState = StCheckHit;					// tag store registers the index at this edge
				end
				else if (writeStart)
				begin
					validWe = 1'b1;							// written data is not cached, drop the line
					writePath = 1'b1;
					dramReq.selectL = 1'b0;					// get DRAM going right away
					nextState = StWrite;
				end
			end
			StCheckHit: nextState = (hit && lineValid) ? StHitWait : StFillStart;
			StHitWait:
			begin
				dtackToCpu = cpu.asL;						// low for as long as the strobe is held
				if (cycleEnd)
				begin
					nextState = StIdle;
				end
			end
			StFillStart:
			begin
				dramReq.selectL = 1'b0;
				tagWe = 1'b1;								// claim the line for the new tag
				validWe = 1'b1;
				validIn = 1'b1;
				if (!dramStatus.casL && dramStatus.rasL)
				begin
					nextState = StCasDelay1;				// read CAS, a refresh has ras low too
				end
			end
			StCasDelay1:
			begin
				dramReq.selectL = 1'b0;
				nextState = StCasDelay2;
			end
			StCasDelay2:
			begin
				dramReq.selectL = 1'b0;
				nextState = StBurstFill;					// first word is on the bus next cycle
			end
			StBurstFill:
			begin
				dramReq.selectL = 1'b0;
				wordWe = 1'b1;
				wordSel = counter[2:0];
				if (counter[2:0] == 3'd7)
				begin
					nextState = StFillDone;
				end
			end
			StFillDone:
			begin
				dtackToCpu = cpu.asL;						// the requested word comes from the filled line
				if (cycleEnd)
				begin
					nextState = StIdle;
				end
			end
			StWrite:
			begin
				writePath = 1'b1;
				dramReq.selectL = 1'b0;
				dtackToCpu = dramStatus.dtackL;				// DRAM decides when the write is done
				if (cycleEnd)
				begin
					nextState = StIdle;
				end
			end
			default: nextState = StReset;
		endcase

		if (writePath)
		begin
			dramReq.address = cpu.address;
			dramReq.udsL = cpu.udsL;
			dramReq.ldsL = cpu.ldsL;
			dramReq.weL = cpu.weL;
		end
	end

	// a fill writes the whole line, eight beats back to back and then stops
	assertFillWrite: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(wordWe) |-> wordWe [*8] ##1 !wordWe)
		else $error("burst fill did not write exactly eight words");

	// the CPU must not see dtack before the line it reads has been filled
	assertNoEarlyDtack: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dramReq.selectL && dramReq.weL) |-> dtackToCpu)
		else $error("dtack to CPU while a read fill is running");

endmodule

`default_nettype wire

/* src/CacheTagStore.sv */
/*
 * Tag and valid memories of the direct mapped cache, one entry per line.
 * Writes use the index as given, reads go through a registered index, so
 * hit and lineValid are good one clock after the index is presented.
 */
`timescale 1ns/1ps
`default_nettype none

module CacheTagStore #(
	parameter int IndexBits = 5,
	localparam int TagBits = $bits(CachePkg::AddressT) - 4 - IndexBits
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic [IndexBits-1:0] index,					// line picked by the sequencer
	input wire logic [TagBits-1:0] tagIn,					// tag of the current CPU address
	input wire logic tagWe,									// store tagIn at index
	input wire logic validIn,
	input wire logic validWe,								// store validIn at index
	output logic hit,										// tag matches and the line is valid
	output logic lineValid
);

	localparam int Lines = 2 ** IndexBits;

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	logic [TagBits-1:0] tagMem [0:Lines-1];					// upper address bits of whatever each line holds
	logic validMem [0:Lines-1];								// cleared line by line after reset
	logic [IndexBits-1:0] indexQ;							// index seen at the last edge

	always_ff @(posedge Clock)
	begin
		if (tagWe)
		begin
			tagMem[index] <= tagIn;							// written while the fill waits for CAS
		end
		if (validWe)
		begin
			validMem[index] <= validIn;						// set on a fill, cleared on invalidate and write
		end
	end

	// the read side sees the line picked in the previous cycle, so the
	// comparison lines up with the sequencer's check state
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			indexQ <= '0;
		end
		else
		begin
			indexQ <= index;
		end
	end

	//////////////////////////////////////////////////
	// hit comparison
	//////////////////////////////////////////////////

	assign lineValid = validMem[indexQ];
	assign hit = lineValid && (tagMem[indexQ] == tagIn);	// tagIn is the live address, held by the CPU

	// a tag is only ever written together with its valid bit, otherwise a
	// stale valid bit could vouch for a line whose tag changed underneath it
	assertTagWithValid: assert property (@(posedge Clock) disable iff (!Reset_L)
		tagWe |-> validWe && validIn)
		else $error("tag written without setting the valid bit");

endmodule

`default_nettype wire

/* src/M68kCache.sv */
/*
 * Top level of the 68000 read cache. Sits between the CPU bus and the
 * SDRAM controller; set IndexBits for the number of lines (2**IndexBits).
 */
`timescale 1ns/1ps
`default_nettype none

module M68kCache #(
	parameter int IndexBits = 5
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire CachePkg::CpuBusT cpu,
	input wire CachePkg::DramStatusT dramStatus,
	output CachePkg::DramReqT dramReq,
	output CachePkg::DataWordT cpuReadData,
	output logic dtackToCpu									// active low
);

	import CachePkg::*;

	localparam int TagBits = $bits(AddressT) - 4 - IndexBits;

	logic [IndexBits-1:0] index;							// shared by both stores
	logic tagWe, validWe, validIn;
	logic hit, lineValid;
	logic wordWe;
	WordSelT wordSel;

	CacheSequencer #(.IndexBits(IndexBits)) sequencer (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.cpu(cpu),
		.dramStatus(dramStatus),
		.hit(hit),
		.lineValid(lineValid),
		.dramReq(dramReq),
		.dtackToCpu(dtackToCpu),
		.index(index),
		.tagWe(tagWe),
		.validWe(validWe),
		.validIn(validIn),
		.wordSel(wordSel),
		.wordWe(wordWe)
	);

	CacheTagStore #(.IndexBits(IndexBits)) tagStore (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.index(index),
		.tagIn(cpu.address[31 -: TagBits]),					// address bits above the index
		.tagWe(tagWe),
		.validIn(validIn),
		.validWe(validWe),
		.hit(hit),
		.lineValid(lineValid)
	);

	CacheDataStore #(.IndexBits(IndexBits)) dataStore (
		.Clock(Clock),
		.index(index),
		.wordSel(wordSel),
		.wordWe(wordWe),
		.writeData(dramStatus.readData),					// fills come straight off the DRAM bus
		.readData(cpuReadData)
	);

endmodule

`default_nettype wire

/* testbench/M68kCacheTb.sv */
/*
 * Testbench for the 68000 read cache. Models the SDRAM controller with a
 * write shadow, runs the bus operations listed in the test data file and
 * checks hit or miss, read data and the write pass through to DRAM.
 */
`timescale 1ns/1ps
`default_nettype none

module M68kCacheTb;

	import CachePkg::*;

	localparam int IndexBits = 5;
	localparam int CasWait = 3;								// select cycles before the read CAS
	localparam int WriteWait = 2;							// select cycles before DRAM dtack
	localparam int OpTimeout = 100;
	localparam int InvalidateTimeout = 2 * (2 ** IndexBits) + 20;
	localparam DataWordT FillConst = 16'ha5c3;

	logic Clock;
	logic Reset_L;
	CpuBusT cpu;
	DramStatusT dramStatus = '{readData: 16'h0000, dtackL: 1'b1, casL: 1'b1, rasL: 1'b1};
	DramReqT dramReq;
	DataWordT cpuReadData;
	logic dtackToCpu;

	int readCount;											// select cycles of the current read
	int writeCount;
	AddressT shadowAddr [0:31];								// word addresses written so far
	DataWordT shadowData [0:31];
	int shadowCount;
	AddressT lastWrAddr;									// the last write as DRAM saw it
	DataWordT lastWrData;
	logic [1:0] lastWrStrobes;
	int writesSeen;
	int errorCount;
	int checkCount;
	logic timedOut;

	M68kCache #(.IndexBits(IndexBits)) dut (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.cpu(cpu),
		.dramStatus(dramStatus),
		.dramReq(dramReq),
		.cpuReadData(cpuReadData),
		.dtackToCpu(dtackToCpu)
	);

	initial Clock = 1'b0;
	always #4 Clock = !Clock;								// 8 ns period

	//////////////////////////////////////////////////
	// DRAM controller model
	//////////////////////////////////////////////////

	// unwritten words fold both halves of the word address into the pattern
	function automatic DataWordT modelWord(input AddressT wordAddr);
		DataWordT value;
		value = wordAddr[15:0] ^ wordAddr[31:16] ^ FillConst;
		for (int i = 0; i < shadowCount; i++)
		begin
			if (shadowAddr[i] == wordAddr)
				value = shadowData[i];						// later entries win
		end
		return value;
	endfunction

	task automatic storeWrite(input AddressT wordAddr, input DataWordT data, input logic [1:0] strobes);
		DataWordT merged;
		merged = modelWord(wordAddr);
		if (!strobes[1])
			merged[15:8] = data[15:8];						// upper byte strobe is active low
		if (!strobes[0])
			merged[7:0] = data[7:0];
		if (shadowCount < 32)
		begin
			shadowAddr[shadowCount] = wordAddr;
			shadowData[shadowCount] = merged;
			shadowCount++;
		end
	endtask

	always @(posedge Clock)
	begin
		AddressT beatAddr;
		beatAddr = {1'b0, dramReq.address[31:1]} + AddressT'(readCount - CasWait - 3);
		if (!Reset_L)
		begin
			readCount <= 0;
			writeCount <= 0;
			dramStatus <= '{readData: 16'h0000, dtackL: 1'b1, casL: 1'b1, rasL: 1'b1};
		end
		else if (!dramReq.selectL && dramReq.weL)
		begin
			readCount <= readCount + 1;
			dramStatus.rasL <= (readCount != 0);			// a refresh comes first and must be ignored
			dramStatus.casL <= !(readCount == 0 || readCount == CasWait);
			if (readCount >= CasWait + 3 && readCount < CasWait + 11)
				dramStatus.readData <= modelWord(beatAddr);	// eight beats in line order
		end
		else if (!dramReq.selectL && !dramReq.weL)
		begin
			writeCount <= writeCount + 1;
			if (writeCount == WriteWait)
			begin
				storeWrite({1'b0, dramReq.address[31:1]}, dramReq.writeData,
					{dramReq.udsL, dramReq.ldsL});
				lastWrAddr <= dramReq.address;
				lastWrData <= dramReq.writeData;
				lastWrStrobes <= {dramReq.udsL, dramReq.ldsL};
				writesSeen <= writesSeen + 1;
				dramStatus.dtackL <= 1'b0;					// held until select goes away
			end
		end
		else
		begin
			readCount <= 0;
			writeCount <= 0;
			dramStatus.dtackL <= 1'b1;
			dramStatus.casL <= 1'b1;
			dramStatus.rasL <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// one CPU bus operation with its checks
	//////////////////////////////////////////////////

	task automatic runOp(input string testName, input logic isWrite, input AddressT addr,
		input DataWordT data, input logic [1:0] strobes, input logic expHit, input DataWordT expData);
		int cycles;
		int writesBefore;
		logic selectSeen;
		logic reqChecked;
		logic gotDtack;
		DataWordT readValue;
		AddressT lineAddr;
		cycles = 0;
		selectSeen = 1'b0;
		reqChecked = 1'b0;
		gotDtack = 1'b0;
		readValue = '0;
		lineAddr = {addr[31:4], 4'h0};						// a fill fetches the line from its first word
		writesBefore = writesSeen;
		@(posedge Clock);
		cpu.address <= addr;
		cpu.writeData <= data;
		cpu.udsL <= strobes[1];
		cpu.ldsL <= strobes[0];
		cpu.weL <= !isWrite;
		cpu.asL <= 1'b0;
		cpu.dramSelect <= 1'b1;
		while (!gotDtack && cycles < OpTimeout)
		begin
			@(negedge Clock);								// outputs are settled mid cycle
			if (!dramReq.selectL)
				selectSeen = 1'b1;							// any DRAM access means the read missed
			if (!dramReq.selectL && dramReq.weL && !reqChecked)
			begin
				reqChecked = 1'b1;							// one look at the fill request per operation
				checkCount++;
				if ({dramReq.address, dramReq.udsL, dramReq.ldsL, dramReq.asL} != {lineAddr, 3'b000})
				begin
					$display("FAIL %s read request: expected %h 000, actual %h %b%b%b", testName,
						lineAddr, dramReq.address, dramReq.udsL, dramReq.ldsL, dramReq.asL);
					errorCount++;
				end
			end
			if (!dtackToCpu)
			begin
				gotDtack = 1'b1;
				readValue = cpuReadData;
			end
			cycles++;
		end
		if (!gotDtack)
		begin
			$display("%s: the cache gave no dtack within %0d cycles", testName, OpTimeout);
			errorCount++;
			timedOut = 1'b1;
		end
		else
		begin
			checkCount++;
			if (selectSeen == expHit)
			begin
				$display("FAIL %s hit: expected %0d, actual %0d", testName, expHit, !selectSeen);
				errorCount++;
			end
			if (isWrite)
			begin
				checkCount += 3;
				if (writesSeen == writesBefore)
				begin
					$display("%s: the write never reached DRAM", testName);
					errorCount++;
				end
				if (lastWrAddr != addr)
				begin
					$display("FAIL %s address: expected %h, actual %h", testName, addr, lastWrAddr);
					errorCount++;
				end
				if (lastWrData != data)
				begin
					$display("FAIL %s data: expected %h, actual %h", testName, data, lastWrData);
					errorCount++;
				end
				if (lastWrStrobes != strobes)
				begin
					$display("FAIL %s strobes: expected %b, actual %b", testName, strobes,
						lastWrStrobes);
					errorCount++;
				end
			end
			else
			begin
				checkCount++;
				if (readValue != expData)
				begin
					$display("FAIL %s data: expected %h, actual %h", testName, expData, readValue);
					errorCount++;
				end
			end
			@(posedge Clock);
			cpu.asL <= 1'b1;								// end the bus cycle, R/W stays put like on a 68000
			cpu.dramSelect <= 1'b0;
			cycles = 0;
			while (gotDtack && cycles < OpTimeout)
			begin
				@(negedge Clock);
				gotDtack = !dtackToCpu;
				cycles++;
			end
			if (gotDtack)
			begin
				$display("%s: dtack stayed low after the strobe was released", testName);
				errorCount++;
				timedOut = 1'b1;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int fd;
		int nread;
		int fields;
		int cycles;
		int opCount;
		string line;
		string testName;
		logic op;
		AddressT addr;
		DataWordT data;
		logic [1:0] strobes;
		logic expHit;
		DataWordT expData;
		cpu.address = '0;
		cpu.writeData = '0;
		cpu.udsL = 1'b1;
		cpu.ldsL = 1'b1;
		cpu.weL = 1'b1;
		cpu.asL = 1'b1;
		cpu.dramSelect = 1'b0;
		Reset_L = 1'b0;
		shadowCount = 0;
		writesSeen = 0;
		errorCount = 0;
		checkCount = 0;
		opCount = 0;
		timedOut = 1'b0;
		repeat (3) @(posedge Clock);
		Reset_L <= 1'b1;

		cycles = 0;
		while (dut.sequencer.state != StIdle && cycles < InvalidateTimeout)
		begin
			@(negedge Clock);
			cycles++;
		end
		if (dut.sequencer.state != StIdle)
		begin
			$display("the cache did not finish clearing its valid bits");
			errorCount++;
			timedOut = 1'b1;
		end

		fd = $fopen("testbench/m68kCache_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			errorCount++;
		end
		else
		begin
			while (!$feof(fd) && !timedOut)
			begin
				line = "";
				nread = $fgets(line, fd);
				if (nread > 1 && line.getc(0) != "#")
				begin
					fields = $sscanf(line, "%s %h %h %h %h %h %h", testName, op, addr, data,
						strobes, expHit, expData);
					if (fields == 7)
					begin
						runOp(testName, op, addr, data, strobes, expHit, expData);
						opCount++;
					end
					else
					begin
						$display("unreadable line in the test data file: %s", line);
						errorCount++;
					end
				end
			end
			$fclose(fd);
		end
		if (opCount == 0)
		begin
			$display("no bus operations were run");
			errorCount++;
		end

		$display("%0d operations, %0d checks, %0d errors", opCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/m68kCache_testdata.txt */
# name  op(0 read, 1 write)  address  writeData  strobes(udsL ldsL)  expHit  expReadData
# an unwritten word reads as word address low half ^ high half ^ a5c3
firstMiss       0 00001236 0000 0 0 acd8
repeatHit       0 00001236 0000 0 1 acd8
lineWord0       0 00001230 0000 0 1 acdb
lineWord1       0 00001232 0000 0 1 acda
lineWord2       0 00001234 0000 0 1 acd9
lineWord3       0 00001236 0000 0 1 acd8
lineWord4       0 00001238 0000 0 1 acdf
lineWord5       0 0000123a 0000 0 1 acde
lineWord6       0 0000123c 0000 0 1 acdd
lineWord7       0 0000123e 0000 0 1 acdc
wordWrite       1 00001234 beef 0 0 0000
readAfterWrite  0 00001234 0000 0 0 beef
sameLineHit     0 00001236 0000 0 1 acd8
byteWrite       1 00001238 5577 2 0 0000
readByteWrite   0 00001238 0000 0 0 ac77
otherTagMiss    0 00001432 0000 0 0 afda
otherTagHit     0 00001432 0000 0 1 afda
firstTagAgain   0 00001236 0000 0 0 acd8
readAfterRefill 0 00001234 0000 0 1 beef
highTagMiss     0 00ff0010 0000 0 0 25b4
highTagHit      0 00ff001e 0000 0 1 25b3
